// ==== source/qam_defines.svh ====
`ifndef QAM_DEFINES_SVH
`define QAM_DEFINES_SVH

// Symbol FIFO entries, must stay a power of two
`define QAM_FIFO_DEPTH 8

// Signed width of each I and Q output sample
`define QAM_SAMPLE_W 10

// Unsigned gain register width
`define QAM_GAIN_W 8

// Register map
`define QAM_REG_GAIN 2'd0
`define QAM_REG_CTRL 2'd1

`endif

// ==== source/qam_pkg.sv ====
package qam_pkg;

	// One 16-QAM symbol, I index in the upper half
	typedef struct packed {
		logic [1:0] i_idx;
		logic [1:0] q_idx;
	} symbol_t;

	// Constellation level, -3 to +3
	typedef logic signed [2:0] level_t;

	typedef logic [1:0] reg_addr_t;

	// Gray-ordered index to level, so adjacent levels differ by one bit
	function automatic level_t idx_to_level(logic [1:0] idx);
		level_t lvl;
		case (idx)
			2'b00: lvl = level_t'(-3);
			2'b01: lvl = level_t'(-1);
			2'b11: lvl = level_t'(1);
			default: lvl = level_t'(3);
		endcase
		return lvl;
	endfunction

endpackage

// ==== source/reset_sync.sv ====
`timescale 1ns/1ps

module reset_sync (
	input  logic i_clk,
	input  logic i_rst_n,
	output logic o_rst_n
);

	logic rst_meta;

	// Assert at once, release after two local edges
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rst_meta <= 1'b0;
			o_rst_n  <= 1'b0;
		end else begin
			rst_meta <= 1'b1;
			o_rst_n  <= rst_meta;
		end
	end

endmodule

// ==== source/baseband_framer.sv ====
`timescale 1ns/1ps

module baseband_framer (
	input  logic             i_data_clk,
	input  logic             i_rst_n,
	input  logic             i_data_in,
	input  logic             i_data_valid,
	output logic             o_data_ready,
	output qam_pkg::symbol_t o_wr_sym,
	output logic             o_wr_en,
	input  logic             i_full
);
	import qam_pkg::*;

	logic [1:0] bit_cnt;
	logic [2:0] shift_reg;
	logic       pending;
	logic       bit_take;
	symbol_t    sym_hold;

	// Stall input only while a finished symbol waits on a full FIFO
	assign o_data_ready = !(pending && i_full);
	assign bit_take     = i_data_valid && o_data_ready;
	assign o_wr_en      = pending && !i_full;
	assign o_wr_sym     = sym_hold;

	always_ff @(posedge i_data_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bit_cnt <= 2'd0;
			pending <= 1'b0;
		end else begin
			if (o_wr_en) begin
				pending <= 1'b0;
			end
			if (bit_take) begin
				bit_cnt <= bit_cnt + 2'd1;
				// Fourth bit closes the symbol
				if (bit_cnt == 2'd3) begin
					pending <= 1'b1;
				end
			end
		end
	end

	// MSB first, first two bits form the I index
	always_ff @(posedge i_data_clk) begin
		if (bit_take) begin
			shift_reg <= {shift_reg[1:0], i_data_in};
			if (bit_cnt == 2'd3) begin
				sym_hold <= symbol_t'({shift_reg, i_data_in});
			end
		end
	end

endmodule

// ==== source/cdc_fifo.sv ====
`timescale 1ns/1ps
`include "qam_defines.svh"

module cdc_fifo #(
	parameter int DEPTH = `QAM_FIFO_DEPTH
) (
	input  logic             i_wr_clk,
	input  logic             i_wr_rst_n,
	input  logic             i_wr_en,
	input  qam_pkg::symbol_t i_wr_data,
	output logic             o_full,
	input  logic             i_rd_clk,
	input  logic             i_rd_rst_n,
	input  logic             i_rd_en,
	output qam_pkg::symbol_t o_rd_data,
	output logic             o_empty
);
	import qam_pkg::*;

	localparam int AW = $clog2(DEPTH);

	symbol_t mem [DEPTH];

	// Pointers carry one extra wrap bit
	logic [AW:0] wr_bin;
	logic [AW:0] wr_bin_nxt;
	logic [AW:0] wr_gray;
	logic [AW:0] wr_gray_nxt;
	logic [AW:0] rd_bin;
	logic [AW:0] rd_bin_nxt;
	logic [AW:0] rd_gray;
	logic [AW:0] rd_gray_nxt;
	logic [AW:0] rd_gray_w1;
	logic [AW:0] rd_gray_w2;
	logic [AW:0] wr_gray_r1;
	logic [AW:0] wr_gray_r2;
	logic        wr_fire;
	logic        rd_fire;

	// Write side
	assign wr_fire     = i_wr_en && !o_full;
	assign wr_bin_nxt  = wr_bin + {{AW{1'b0}}, wr_fire};
	assign wr_gray_nxt = wr_bin_nxt ^ (wr_bin_nxt >> 1);

	always_ff @(posedge i_wr_clk or negedge i_wr_rst_n) begin
		if (!i_wr_rst_n) begin
			wr_bin     <= '0;
			wr_gray    <= '0;
			rd_gray_w1 <= '0;
			rd_gray_w2 <= '0;
		end else begin
			wr_bin     <= wr_bin_nxt;
			wr_gray    <= wr_gray_nxt;
			rd_gray_w1 <= rd_gray;
			rd_gray_w2 <= rd_gray_w1;
		end
	end

	always_ff @(posedge i_wr_clk) begin
		if (wr_fire) begin
			mem[wr_bin[AW-1:0]] <= i_wr_data;
		end
	end

	// Full when the write pointer is one lap ahead of the synced read pointer.
	// The stale read pointer only makes this late to release.
	assign o_full = (wr_gray == {~rd_gray_w2[AW:AW-1], rd_gray_w2[AW-2:0]});

	// Read side
	assign rd_fire     = i_rd_en && !o_empty;
	assign rd_bin_nxt  = rd_bin + {{AW{1'b0}}, rd_fire};
	assign rd_gray_nxt = rd_bin_nxt ^ (rd_bin_nxt >> 1);

	always_ff @(posedge i_rd_clk or negedge i_rd_rst_n) begin
		if (!i_rd_rst_n) begin
			rd_bin     <= '0;
			rd_gray    <= '0;
			wr_gray_r1 <= '0;
			wr_gray_r2 <= '0;
		end else begin
			rd_bin     <= rd_bin_nxt;
			rd_gray    <= rd_gray_nxt;
			wr_gray_r1 <= wr_gray;
			wr_gray_r2 <= wr_gray_r1;
		end
	end

	assign o_empty = (rd_gray == wr_gray_r2);

	// Head entry shown ahead of the pop
	assign o_rd_data = mem[rd_bin[AW-1:0]];

endmodule

// ==== source/cfg_regs.sv ====
`timescale 1ns/1ps
`include "qam_defines.svh"

module cfg_regs (
	input  logic                   i_dsp_clk,
	input  logic                   i_rst_n,
	input  logic                   i_cfg_req,
	input  qam_pkg::reg_addr_t     i_cfg_addr,
	input  logic [`QAM_GAIN_W-1:0] i_cfg_wdata,
	output logic                   o_cfg_ack,
	output logic [`QAM_GAIN_W-1:0] o_gain,
	output logic                   o_enable
);

	logic req_meta;
	logic write_stb;

	// Synced req is high but ack has not followed yet
	assign write_stb = req_meta && !o_cfg_ack;

	// Ack is the second synchronizer stage of req
	always_ff @(posedge i_dsp_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			req_meta  <= 1'b0;
			o_cfg_ack <= 1'b0;
		end else begin
			req_meta  <= i_cfg_req;
			o_cfg_ack <= req_meta;
		end
	end

	// Address and data are held stable by the master while req is high
	always_ff @(posedge i_dsp_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_gain   <= `QAM_GAIN_W'(1);
			o_enable <= 1'b0;
		end else if (write_stb) begin
			case (i_cfg_addr)
				`QAM_REG_GAIN: begin
					o_gain <= i_cfg_wdata;
				end
				`QAM_REG_CTRL: begin
					o_enable <= i_cfg_wdata[0];
				end
				default: begin
					// Unused address, acked without effect
				end
			endcase
		end
	end

endmodule

// ==== source/symbol_mapper.sv ====
`timescale 1ns/1ps
`include "qam_defines.svh"

module symbol_mapper (
	input  logic                            i_dsp_clk,
	input  logic                            i_rst_n,
	input  qam_pkg::symbol_t                i_sym,
	input  logic                            i_empty,
	output logic                            o_rd_en,
	input  logic [`QAM_GAIN_W-1:0]          i_gain,
	input  logic                            i_enable,
	output logic signed [`QAM_SAMPLE_W-1:0] o_i_out,
	output logic signed [`QAM_SAMPLE_W-1:0] o_q_out,
	output logic                            o_iq_valid
);
	import qam_pkg::*;

	localparam int SW = `QAM_SAMPLE_W;
	localparam int PW = `QAM_GAIN_W + 4;
	localparam logic signed [PW-1:0] SAT_MAX = PW'((2 ** (SW - 1)) - 1);
	localparam logic signed [PW-1:0] SAT_MIN = -SAT_MAX;

	// Level times gain, clipped to the symmetric sample range
	function automatic logic signed [SW-1:0] scale(level_t lvl, logic [`QAM_GAIN_W-1:0] gain);
		logic signed [PW-1:0] prod;
		logic signed [SW-1:0] res;
		prod = PW'(lvl) * $signed({1'b0, gain});
		if (prod > SAT_MAX) begin
			res = SW'(SAT_MAX);
		end else if (prod < SAT_MIN) begin
			res = SW'(SAT_MIN);
		end else begin
			res = SW'(prod);
		end
		return res;
	endfunction

	// One pop per cycle while enabled and data is there
	assign o_rd_en = i_enable && !i_empty;

	always_ff @(posedge i_dsp_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_iq_valid <= 1'b0;
		end else begin
			o_iq_valid <= o_rd_en;
		end
	end

	// Sample lands one cycle after its pop
	always_ff @(posedge i_dsp_clk) begin
		if (o_rd_en) begin
			o_i_out <= scale(idx_to_level(i_sym.i_idx), i_gain);
			o_q_out <= scale(idx_to_level(i_sym.q_idx), i_gain);
		end
	end

endmodule

// ==== source/qam_top.sv ====
`timescale 1ns/1ps
`include "qam_defines.svh"

module qam_top (
	input  logic                            i_data_clk,
	input  logic                            i_dsp_clk,
	input  logic                            i_rst_n,
	// Serial baseband input
	input  logic                            i_data_in,
	input  logic                            i_data_valid,
	output logic                            o_data_ready,
	// Register port
	input  logic                            i_cfg_req,
	input  qam_pkg::reg_addr_t              i_cfg_addr,
	input  logic [`QAM_GAIN_W-1:0]          i_cfg_wdata,
	output logic                            o_cfg_ack,
	// Samples, DSP domain
	output logic signed [`QAM_SAMPLE_W-1:0] o_i_out,
	output logic signed [`QAM_SAMPLE_W-1:0] o_q_out,
	output logic                            o_iq_valid
);
	import qam_pkg::*;

	logic                   rst_n_data;
	logic                   rst_n_dsp;
	symbol_t                wr_sym;
	logic                   wr_en;
	logic                   fifo_full;
	symbol_t                rd_sym;
	logic                   rd_en;
	logic                   fifo_empty;
	logic [`QAM_GAIN_W-1:0] gain;
	logic                   enable;

	// One reset synchronizer per clock domain
	reset_sync rst_data (
		.i_clk   (i_data_clk),
		.i_rst_n (i_rst_n),
		.o_rst_n (rst_n_data)
	);

	reset_sync rst_dsp (
		.i_clk   (i_dsp_clk),
		.i_rst_n (i_rst_n),
		.o_rst_n (rst_n_dsp)
	);

	baseband_framer u_framer (
		.i_data_clk   (i_data_clk),
		.i_rst_n      (rst_n_data),
		.i_data_in    (i_data_in),
		.i_data_valid (i_data_valid),
		.o_data_ready (o_data_ready),
		.o_wr_sym     (wr_sym),
		.o_wr_en      (wr_en),
		.i_full       (fifo_full)
	);

	// Symbols cross from data clock to DSP clock
	cdc_fifo #(.DEPTH(`QAM_FIFO_DEPTH)) u_sym_fifo (
		.i_wr_clk   (i_data_clk),
		.i_wr_rst_n (rst_n_data),
		.i_wr_en    (wr_en),
		.i_wr_data  (wr_sym),
		.o_full     (fifo_full),
		.i_rd_clk   (i_dsp_clk),
		.i_rd_rst_n (rst_n_dsp),
		.i_rd_en    (rd_en),
		.o_rd_data  (rd_sym),
		.o_empty    (fifo_empty)
	);

	cfg_regs u_cfg (
		.i_dsp_clk   (i_dsp_clk),
		.i_rst_n     (rst_n_dsp),
		.i_cfg_req   (i_cfg_req),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.o_cfg_ack   (o_cfg_ack),
		.o_gain      (gain),
		.o_enable    (enable)
	);

	symbol_mapper u_mapper (
		.i_dsp_clk  (i_dsp_clk),
		.i_rst_n    (rst_n_dsp),
		.i_sym      (rd_sym),
		.i_empty    (fifo_empty),
		.o_rd_en    (rd_en),
		.i_gain     (gain),
		.i_enable   (enable),
		.o_i_out    (o_i_out),
		.o_q_out    (o_q_out),
		.o_iq_valid (o_iq_valid)
	);

endmodule

// ==== tb/qam_chk.sv ====
`timescale 1ns/1ps
`include "qam_defines.svh"

module qam_chk (
	input logic i_dsp_clk,
	input logic i_data_clk,
	input logic i_rst_n,
	input logic i_cfg_req,
	input logic i_cfg_ack,
	input logic i_iq_valid,
	input logic i_wr_en,
	input logic i_rd_en
);

	localparam int CW = $clog2(`QAM_FIFO_DEPTH) + 1;

	logic [CW-1:0] wr_count;
	logic [CW-1:0] rd_count;
	logic [CW-1:0] fill;

	// Push and pop counts in their own clock domains
	always_ff @(posedge i_data_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_count <= '0;
		end else if (i_wr_en) begin
			wr_count <= wr_count + CW'(1);
		end
	end

	always_ff @(posedge i_dsp_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rd_count <= '0;
		end else if (i_rd_en) begin
			rd_count <= rd_count + CW'(1);
		end
	end

	assign fill = wr_count - rd_count;

	// Four-phase order on the register port
	ack_rise_with_req: assert property (@(posedge i_dsp_clk) disable iff (!i_rst_n)
		$rose(i_cfg_ack) |-> $past(i_cfg_req))
		else $error("cfg ack rose while req was low");

	ack_fall_after_req: assert property (@(posedge i_dsp_clk) disable iff (!i_rst_n)
		$fell(i_cfg_ack) |-> !$past(i_cfg_req))
		else $error("cfg ack fell while req was high");

	// Mapper stays quiet under reset
	valid_low_in_reset: assert property (@(posedge i_dsp_clk) !i_rst_n |-> !i_iq_valid)
		else $error("sample valid during reset");

	// True occupancy is below depth whenever a symbol is pushed
	no_write_when_full: assert property (@(posedge i_data_clk) disable iff (!i_rst_n)
		i_wr_en |-> (fill < CW'(`QAM_FIFO_DEPTH)))
		else $error("FIFO written while full");

endmodule

bind qam_top qam_chk chk_inst (
	.i_dsp_clk  (i_dsp_clk),
	.i_data_clk (i_data_clk),
	.i_rst_n    (i_rst_n),
	.i_cfg_req  (i_cfg_req),
	.i_cfg_ack  (o_cfg_ack),
	.i_iq_valid (o_iq_valid),
	.i_wr_en    (wr_en),
	.i_rd_en    (rd_en)
);

// ==== tb/qam_tb.sv ====
`timescale 1ns/1ps
`include "qam_defines.svh"

module qam_tb;
	import qam_pkg::*;

	localparam int ROUND_BITS = 64;
	localparam int MAP_ROUNDS = 6;
	localparam int ROUNDS = 10;
	// Mapping and saturation rounds, register round and the back-pressure fill
	localparam int NUM_BITS = (ROUNDS + 2) * ROUND_BITS;
	localparam int TIMEOUT_NS = NUM_BITS * 13 * 4 + 20000;

	logic                            i_data_clk;
	logic                            i_dsp_clk;
	logic                            i_rst_n;
	logic                            i_data_in;
	logic                            i_data_valid;
	logic                            o_data_ready;
	logic                            i_cfg_req;
	reg_addr_t                       i_cfg_addr;
	logic [`QAM_GAIN_W-1:0]          i_cfg_wdata;
	logic                            o_cfg_ack;
	logic signed [`QAM_SAMPLE_W-1:0] o_i_out;
	logic signed [`QAM_SAMPLE_W-1:0] o_q_out;
	logic                            o_iq_valid;

	// Reference model state
	int         seed;
	int         rnd;
	int         errors;
	int         checks;
	int         model_gain;
	logic       model_en;
	string      test_name;
	logic [3:0] exp_q[$];
	logic [3:0] bit_acc;
	logic [3:0] out_sym;

	qam_top qam_top_inst (.*);

	initial begin
		i_dsp_clk = 1'b0;
		forever #4 i_dsp_clk = ~i_dsp_clk;
	end

	initial begin
		i_data_clk = 1'b0;
		forever #6.5 i_data_clk = ~i_data_clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before all tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	task automatic report_failure(input string msg);
		errors++;
		$display("error %s: %s", test_name, msg);
	endtask

	task automatic check_value(input string what, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("error %s: %s expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	// Index to level, times gain, clipped to the symmetric 10-bit range
	function automatic int expected_sample(input logic [1:0] idx, input int gain);
		int v;
		case (idx)
			2'b00: v = -3 * gain;
			2'b01: v = -gain;
			2'b11: v = gain;
			default: v = 3 * gain;
		endcase
		return (v > 511) ? 511 : ((v < -511) ? -511 : v);
	endfunction

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge i_dsp_clk) begin
		if (o_iq_valid === 1'b1) begin
			if (!model_en || exp_q.size() == 0) begin
				report_failure("a sample came out with no symbol expected");
			end else begin
				out_sym = exp_q.pop_front();
				check_value("I", expected_sample(out_sym[3:2], model_gain), int'(o_i_out));
				check_value("Q", expected_sample(out_sym[1:0], model_gain), int'(o_q_out));
			end
		end
	end

	// A bit counts when ready is high at the falling edge it is offered on
	task automatic offer_bits(input int nbits, input logic until_stall);
		int taken;
		taken = 0;
		@(negedge i_data_clk);
		while (taken < nbits && (o_data_ready || !until_stall)) begin
			rnd = $random(seed);
			i_data_valid = until_stall || (rnd[2:1] != 2'b00);
			i_data_in = rnd[0];
			if (i_data_valid && o_data_ready) begin
				bit_acc = {bit_acc[2:0], rnd[0]};
				taken++;
				if (taken % 4 == 0)
					exp_q.push_back(bit_acc);
			end
			@(negedge i_data_clk);
		end
		i_data_valid = 1'b0;
	endtask

	// Four-phase write with req up, ack up, req down and ack down
	task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
		int n;
		@(negedge i_dsp_clk);
		if (addr == `QAM_REG_GAIN)
			model_gain = int'(data);
		model_en = model_en || (addr == `QAM_REG_CTRL && data[0]);
		i_cfg_addr = addr;
		i_cfg_wdata = data;
		i_cfg_req = 1'b1;
		for (n = 0; n < 8 && !o_cfg_ack; n++)
			@(negedge i_dsp_clk);
		if (!o_cfg_ack)
			report_failure("cfg ack did not rise after req");
		i_cfg_req = 1'b0;
		for (n = 0; n < 8 && o_cfg_ack; n++)
			@(negedge i_dsp_clk);
		if (o_cfg_ack)
			report_failure("cfg ack did not fall after req dropped");
		if (addr == `QAM_REG_CTRL)
			model_en = data[0];
	endtask

	// Wait for the model queue to empty, then watch a while for extra samples
	task automatic wait_drain();
		int n;
		for (n = 0; n < 400 && exp_q.size() != 0; n++)
			@(negedge i_dsp_clk);
		if (exp_q.size() != 0)
			report_failure("symbols never reached the output");
		exp_q.delete();
		repeat (8) @(negedge i_dsp_clk);
	endtask

	initial begin
		int r;
		seed = 22;
		errors = 0;
		checks = 0;
		model_gain = 1;
		model_en = 1'b0;
		bit_acc = 4'd0;
		test_name = "reset";
		i_rst_n = 1'b0;
		i_data_in = 1'b0;
		i_data_valid = 1'b0;
		i_cfg_req = 1'b0;
		i_cfg_addr = '0;
		i_cfg_wdata = '0;
		repeat (8) @(posedge i_dsp_clk);
		@(negedge i_dsp_clk);
		i_rst_n = 1'b1;
		repeat (8) @(negedge i_dsp_clk);
		check_value("o_iq_valid", 0, int'(o_iq_valid));
		check_value("o_cfg_ack", 0, int'(o_cfg_ack));
		check_value("o_data_ready", 1, int'(o_data_ready));

		// Unused addresses get acked but must leave gain and enable alone
		test_name = "register";
		rnd = $random(seed) & 32'h7fff_ffff;
		write_reg(`QAM_REG_GAIN, 8'(1 + rnd % 170));
		write_reg(`QAM_REG_CTRL, 8'd1);
		write_reg(2'd2, ~8'(model_gain));
		write_reg(2'd3, 8'd0);
		offer_bits(ROUND_BITS, 1'b0);
		wait_drain();

		for (r = 0; r < ROUNDS; r++) begin
			rnd = $random(seed) & 32'h7fff_ffff;
			test_name = (r < MAP_ROUNDS) ? "mapping" : "saturation";
			if (r < MAP_ROUNDS)
				write_reg(`QAM_REG_GAIN, 8'(1 + rnd % 170));
			else
				write_reg(`QAM_REG_GAIN, 8'(171 + rnd % 85));
			offer_bits(ROUND_BITS, 1'b0);
			wait_drain();
		end

		// Mapper off, so FIFO fills and the framer holds one more symbol
		test_name = "backpressure";
		write_reg(`QAM_REG_CTRL, 8'd0);
		offer_bits(ROUND_BITS, 1'b1);
		if (o_data_ready)
			report_failure("o_data_ready stayed high with the mapper disabled");
		check_value("held symbols", `QAM_FIFO_DEPTH + 1, exp_q.size());
		repeat (20) @(negedge i_dsp_clk);
		write_reg(`QAM_REG_CTRL, 8'd1);
		wait_drain();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+source
source/qam_pkg.sv
source/reset_sync.sv
source/baseband_framer.sv
source/cdc_fifo.sv
source/cfg_regs.sv
source/symbol_mapper.sv
source/qam_top.sv
tb/qam_chk.sv
tb/qam_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = qam_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
